// File: scan_cfg.svh
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// Number of nonces tried by one scan request
// Kept small for simulation, the hardware scan range is much larger
`define SCAN_LIMIT 16

// Keccak-f[1600] round count
`define KECCAK_ROUNDS 24

`endif

// File: scan_pkg.sv
`default_nettype none

package scan_pkg;

    // One 64-bit Keccak lane
    typedef logic [63:0] lane_t;

    // Lane i sits at x = i mod 5, y = i div 5
    typedef lane_t [24:0] keccak_state_t;

    // Block template, 20 words of 32 bits, word 19 is the start nonce
    typedef logic [19:0][31:0] template_t;

    typedef struct packed {
        template_t template;
        lane_t     threshold;
    } scan_req_t;

    // Index counts from the start nonce, not an absolute nonce
    typedef struct packed {
        logic          found;
        logic [31:0]   index;
        keccak_state_t hash;
    } scan_result_t;

    typedef enum logic [1:0] {
        scan_waiting,
        scan_dispatching,
        scan_flushing
    } scan_state_e;

endpackage

`default_nettype wire

// File: scan_fsm.sv
`default_nettype none

module scan_fsm
    import scan_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic req_valid,
    output logic req_ready,
    output logic capture,
    input  logic found,
    input  logic exhausted,
    input  logic drained,
    output logic feed_valid,
    output logic busy
);

    scan_state_e state_q;
    scan_state_e state_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= scan_waiting;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            scan_waiting: begin
                if (capture) begin
                    state_d = scan_dispatching;
                end
            end
            scan_dispatching: begin
                // One more block may still go out while found rises
                if (found || exhausted) begin
                    state_d = scan_flushing;
                end
            end
            scan_flushing: begin
                // Every dispatched block has to come back first
                if (drained) begin
                    state_d = scan_waiting;
                end
            end
            default: begin
                state_d = scan_waiting;
            end
        endcase
    end

    assign req_ready = (state_q == scan_waiting);
    assign capture   = req_valid && req_ready;
    assign busy      = (state_q != scan_waiting);

    // Never dispatch past the end of the nonce range
    assign feed_valid = (state_q == scan_dispatching) && !exhausted;

endmodule

`default_nettype wire

// File: nonce_counter.sv
`default_nettype none

`include "scan_cfg.svh"

module nonce_counter (
    input  logic        clk,
    input  logic        reset,
    input  logic        capture,
    input  logic        transfer,
    input  logic        hash_valid,
    output logic [31:0] dispatch_count,
    output logic [31:0] return_count,
    output logic        exhausted,
    output logic        drained
);

    always_ff @(posedge clk) begin
        if (reset || capture) begin
            dispatch_count <= 32'd0;
        end else if (transfer) begin
            dispatch_count <= dispatch_count + 32'd1;
        end
    end

    // Also the index of the hash arriving in this cycle
    always_ff @(posedge clk) begin
        if (reset || capture) begin
            return_count <= 32'd0;
        end else if (hash_valid) begin
            return_count <= return_count + 32'd1;
        end
    end

    assign exhausted = (dispatch_count == 32'(`SCAN_LIMIT));
    assign drained   = (return_count == dispatch_count);

endmodule

`default_nettype wire

// File: block_loader.sv
`default_nettype none

module block_loader
    import scan_pkg::*;
(
    input  logic          clk,
    input  logic          capture,
    input  template_t     template,
    input  logic [31:0]   dispatch_count,
    output keccak_state_t feed_state
);

    // Words 0 to 18 stay fixed for the whole scan
    logic [18:0][31:0] words_q;
    logic [31:0]       base_nonce_q;
    logic [31:0]       nonce;

    always_ff @(posedge clk) begin
        if (capture) begin
            words_q      <= template[18:0];
            base_nonce_q <= template[19];
        end
    end

    assign nonce = base_nonce_q + dispatch_count;

    always_comb begin
        feed_state = '0;

        // Lanes 0 to 8, odd word in the high half
        for (int i = 0; i < 9; i++) begin
            feed_state[i] = {words_q[2*i+1], words_q[2*i]};
        end

        feed_state[9] = {nonce, words_q[18]};

        // Padding: first bit after the message and the rate's last bit
        feed_state[10] = 64'h0000_0000_0000_0001;
        feed_state[16] = 64'h8000_0000_0000_0000;
    end

endmodule

`default_nettype wire

// File: keccak_core.sv
`default_nettype none

`include "scan_cfg.svh"

module keccak_core
    import scan_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          feed_valid,
    input  keccak_state_t feed_state,
    output logic          feed_ready,
    output logic          hash_valid,
    output keccak_state_t hash_state
);

    // Rho offsets indexed by lane x + 5*y
    localparam int ROT [25] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    // Iota constants
    localparam lane_t RC [24] = '{
        64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
        64'h8000_0000_0000_808A, 64'h8000_0000_8000_8000,
        64'h0000_0000_0000_808B, 64'h0000_0000_8000_0001,
        64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
        64'h0000_0000_0000_008A, 64'h0000_0000_0000_0088,
        64'h0000_0000_8000_8009, 64'h0000_0000_8000_000A,
        64'h0000_0000_8000_808B, 64'h8000_0000_0000_008B,
        64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
        64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
        64'h0000_0000_0000_800A, 64'h8000_0000_8000_000A,
        64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
        64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
    };

    keccak_state_t state_q;
    logic [4:0]    round_q;
    logic          active_q;
    logic          hash_valid_q;
    logic          transfer;

    function automatic lane_t rotl(input lane_t v, input int unsigned n);
        return (v << n) | (v >> (64 - n));
    endfunction

    function automatic keccak_state_t keccak_round(input keccak_state_t a, input lane_t rc);
        lane_t         c [5];
        lane_t         d [5];
        keccak_state_t t;
        keccak_state_t b;
        keccak_state_t r;

        // Theta
        for (int x = 0; x < 5; x++) begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
        end
        for (int x = 0; x < 5; x++) begin
            d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
        end
        for (int i = 0; i < 25; i++) begin
            t[i] = a[i] ^ d[i%5];
        end

        // Rho and pi, lane (x, y) moves to (y, 2x + 3y)
        for (int x = 0; x < 5; x++) begin
            for (int y = 0; y < 5; y++) begin
                b[y + 5*((2*x + 3*y) % 5)] = rotl(t[x + 5*y], ROT[x + 5*y]);
            end
        end

        // Chi
        for (int x = 0; x < 5; x++) begin
            for (int y = 0; y < 5; y++) begin
                r[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
            end
        end

        // Iota
        r[0] = r[0] ^ rc;
        return r;
    endfunction

    // Busy from acceptance through the hash_valid cycle
    assign feed_ready = !active_q && !hash_valid_q;
    assign transfer   = feed_valid && feed_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q     <= 1'b0;
            hash_valid_q <= 1'b0;
            round_q      <= 5'd0;
        end else begin
            hash_valid_q <= 1'b0;
            if (transfer) begin
                active_q <= 1'b1;
                round_q  <= 5'd0;
            end else if (active_q) begin
                round_q <= round_q + 5'd1;
                if (round_q == 5'(`KECCAK_ROUNDS - 1)) begin
                    active_q     <= 1'b0;
                    hash_valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            state_q <= feed_state;
        end else if (active_q) begin
            state_q <= keccak_round(state_q, RC[round_q]);
        end
    end

    assign hash_valid = hash_valid_q;
    assign hash_state = state_q;

endmodule

`default_nettype wire

// File: scan_result.sv
`default_nettype none

module scan_result
    import scan_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          capture,
    input  lane_t         threshold,
    input  logic          hash_valid,
    input  keccak_state_t hash_state,
    input  logic [31:0]   return_count,
    output logic          found,
    output scan_result_t  result
);

    lane_t         threshold_q;
    logic          found_q;
    logic [31:0]   index_q;
    keccak_state_t hash_q;
    logic          hit;

    // Unsigned compare on lane 3
    assign hit = hash_valid && (hash_state[3] <= threshold_q);

    always_ff @(posedge clk) begin
        if (capture) begin
            threshold_q <= threshold;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || capture) begin
            found_q <= 1'b0;
        end else if (hit) begin
            found_q <= 1'b1;
        end
    end

    // Only the first hit since capture is kept
    always_ff @(posedge clk) begin
        if (capture) begin
            index_q <= 32'd0;
            hash_q  <= '0;
        end else if (hit && !found_q) begin
            index_q <= return_count;
            hash_q  <= hash_state;
        end
    end

    assign found  = found_q;
    assign result = '{found: found_q, index: index_q, hash: hash_q};

endmodule

`default_nettype wire

// File: sha3_scanner.sv
`default_nettype none

module sha3_scanner
    import scan_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         req_valid,
    input  scan_req_t    req,
    output logic         req_ready,
    output logic         busy,
    output scan_result_t result
);

    logic          capture;
    logic          found;
    logic          exhausted;
    logic          drained;
    logic          feed_valid;
    logic          feed_ready;
    logic          transfer;
    logic          hash_valid;
    logic [31:0]   dispatch_count;
    logic [31:0]   return_count;
    keccak_state_t feed_state;
    keccak_state_t hash_state;

    assign transfer = feed_valid && feed_ready;

    scan_fsm i_scan_fsm (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .capture    (capture),
        .found      (found),
        .exhausted  (exhausted),
        .drained    (drained),
        .feed_valid (feed_valid),
        .busy       (busy)
    );

    nonce_counter i_nonce_counter (
        .clk            (clk),
        .reset          (reset),
        .capture        (capture),
        .transfer       (transfer),
        .hash_valid     (hash_valid),
        .dispatch_count (dispatch_count),
        .return_count   (return_count),
        .exhausted      (exhausted),
        .drained        (drained)
    );

    block_loader i_block_loader (
        .clk            (clk),
        .capture        (capture),
        .template       (req.template),
        .dispatch_count (dispatch_count),
        .feed_state     (feed_state)
    );

    keccak_core i_keccak_core (
        .clk        (clk),
        .reset      (reset),
        .feed_valid (feed_valid),
        .feed_state (feed_state),
        .feed_ready (feed_ready),
        .hash_valid (hash_valid),
        .hash_state (hash_state)
    );

    scan_result i_scan_result (
        .clk          (clk),
        .reset        (reset),
        .capture      (capture),
        .threshold    (req.threshold),
        .hash_valid   (hash_valid),
        .hash_state   (hash_state),
        .return_count (return_count),
        .found        (found),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: tb_keccak_model.svh
`ifndef TB_KECCAK_MODEL_SVH
`define TB_KECCAK_MODEL_SVH

// Output bit t of the LFSR x^8 + x^6 + x^5 + x^4 + 1
function automatic logic lfsr_bit(input int t);
    logic [7:0] r;
    r = 8'h01;
    for (int i = 0; i < t % 255; i++) begin
        r = {r[6:0], 1'b0} ^ (r[7] ? 8'h71 : 8'h00);
    end
    return r[0];
endfunction

// Only bit positions 2^j - 1 can be set
function automatic lane_t round_constant(input int ir);
    lane_t rc;
    rc = '0;
    for (int j = 0; j < 7; j++) begin
        rc[(1 << j) - 1] = lfsr_bit(j + 7 * ir);
    end
    return rc;
endfunction

function automatic lane_t rol64(input lane_t v, input int n);
    int s;
    s = n % 64;
    if (s == 0) begin
        return v;
    end
    return (v << s) | (v >> (64 - s));
endfunction

function automatic keccak_state_t permute(input keccak_state_t s);
    lane_t         a [25];
    lane_t         b [25];
    lane_t         c [5];
    int            rho [25];
    int            x;
    int            y;
    int            nx;
    int            src;
    keccak_state_t r;
    for (int i = 0; i < 25; i++) begin
        a[i] = s[i];
    end
    // Rho offsets follow the walk (x, y) to (y, 2x + 3y) from (1, 0)
    rho[0] = 0;
    x = 1;
    y = 0;
    for (int t = 0; t < 24; t++) begin
        rho[x + 5 * y] = ((t + 1) * (t + 2) / 2) % 64;
        nx = y;
        y = (2 * x + 3 * y) % 5;
        x = nx;
    end
    for (int ir = 0; ir < `KECCAK_ROUNDS; ir++) begin
        for (int i = 0; i < 5; i++) begin
            c[i] = a[i] ^ a[i + 5] ^ a[i + 10] ^ a[i + 15] ^ a[i + 20];
        end
        for (int i = 0; i < 25; i++) begin
            a[i] = a[i] ^ c[(i + 4) % 5] ^ rol64(c[(i + 1) % 5], 1);
        end
        // Lane (x, y) takes lane (x + 3y, x), rotated at its old place
        for (int i = 0; i < 25; i++) begin
            src = (i % 5 + 3 * (i / 5)) % 5 + 5 * (i % 5);
            b[i] = rol64(a[src], rho[src]);
        end
        for (int i = 0; i < 25; i++) begin
            x = i % 5;
            y = i / 5;
            a[i] = b[i] ^ (~b[(x + 1) % 5 + 5 * y] & b[(x + 2) % 5 + 5 * y]);
        end
        a[0] = a[0] ^ round_constant(ir);
    end
    for (int i = 0; i < 25; i++) begin
        r[i] = a[i];
    end
    return r;
endfunction

// Message in lanes 0 to 9, pad bits in lanes 10 and 16
function automatic keccak_state_t build_block(input template_t tpl, input int idx);
    keccak_state_t s;
    s = '0;
    for (int w = 0; w < 18; w++) begin
        s[w / 2][32 * (w % 2) +: 32] = tpl[w];
    end
    s[9] = {tpl[19] + 32'(idx), tpl[18]};
    s[10] = 64'd1;
    s[16] = {1'b1, 63'd0};
    return s;
endfunction

// The core may take one block past the hit before dispatch stops
task automatic predict_scan(input scan_req_t r, output scan_result_t exp, output int hashes);
    keccak_state_t h;
    exp = '0;
    hashes = `SCAN_LIMIT;
    for (int k = 0; k < `SCAN_LIMIT && !exp.found; k++) begin
        h = permute(build_block(r.template, k));
        if (h[3] <= r.threshold) begin
            exp.found = 1'b1;
            exp.index = k;
            exp.hash = h;
            hashes = (k + 2 < `SCAN_LIMIT) ? k + 2 : `SCAN_LIMIT;
        end
    end
endtask

`endif

// File: tb_sha3_scanner.sv
`default_nettype none

`include "scan_cfg.svh"

module tb_sha3_scanner
    import scan_pkg::*;
();

    localparam int NUM_SCANS = 12;
    localparam int MAX_CYCLES = NUM_SCANS * (`SCAN_LIMIT + 2) * 27 + 200;

    logic         clk;
    logic         reset;
    logic         req_valid;
    scan_req_t    req;
    logic         req_ready;
    logic         busy;
    scan_result_t result;
    int           seed;
    int           errors;
    int           checks;
    int           cycles;
    int           hashes_seen;

    sha3_scanner i_sha3_scanner (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .busy      (busy),
        .result    (result)
    );

    `include "tb_keccak_model.svh"

    always #5 clk = ~clk;

    // Hash count restarts with every accepted request
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (req_valid && req_ready) begin
            hashes_seen <= 0;
        end else if (i_sha3_scanner.hash_valid) begin
            hashes_seen <= hashes_seen + 1;
        end
    end

    always @(posedge clk) begin
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a scan never finished", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Threshold is a random lane with set_bits forced high, then masked by keep_bits
    function automatic scan_req_t random_req(input lane_t set_bits, input lane_t keep_bits);
        scan_req_t r;
        for (int i = 0; i < 20; i++) begin
            r.template[i] = $random(seed);
        end
        r.threshold[63:32] = $random(seed);
        r.threshold[31:0] = $random(seed);
        r.threshold = (r.threshold | set_bits) & keep_bits;
        return r;
    endfunction

    task automatic wait_ready();
        while (!req_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic verify_result(input scan_req_t r, input string tag);
        scan_result_t exp;
        int           hashes;
        predict_scan(r, exp, hashes);
        check_equal(busy, 0, {tag, " busy at end"});
        check_equal(result.found, exp.found, {tag, " found"});
        check_equal(hashes_seen, hashes, {tag, " hashes returned"});
        if (exp.found) begin
            check_equal(result.index, exp.index, {tag, " index"});
            for (int i = 0; i < 25; i++) begin
                check_equal(result.hash[i], exp.hash[i], $sformatf("%s lane %0d", tag, i));
            end
        end
    endtask

    task automatic run_scan(input scan_req_t r, input string tag);
        wait_ready();
        req = r;
        req_valid = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        check_equal(busy, 1, {tag, " busy after request"});
        check_equal(result.found, 0, {tag, " result cleared"});
        wait_ready();
        verify_result(r, tag);
    endtask

    // req_valid stays high, so each new request is taken as soon as the last one ends
    task automatic back_to_back(input int count);
        scan_req_t r;
        wait_ready();
        req_valid = 1'b1;
        for (int n = 0; n < count; n++) begin
            r = random_req({1'b1, 63'd0}, '1);
            req = r;
            @(negedge clk);
            check_equal(req_ready, 0, "back-to-back request taken");
            check_equal(result.found, 0, "back-to-back result cleared");
            wait_ready();
            verify_result(r, "back-to-back");
        end
        req_valid = 1'b0;
    endtask

    task automatic request_while_busy();
        scan_req_t a;
        scan_req_t b;
        a = random_req({1'b1, 63'd0}, '1);
        b = random_req('1, '1);
        wait_ready();
        req = a;
        req_valid = 1'b1;
        @(negedge clk);
        req = b;
        wait_ready();
        verify_result(a, "scan under pending request");
        @(negedge clk);
        req_valid = 1'b0;
        wait_ready();
        verify_result(b, "pending request");
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        seed = 32'h8361;
        errors = 0;
        checks = 0;
        cycles = 0;
        hashes_seen = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_equal(req_ready, 1, "req_ready after reset");
        check_equal(busy, 0, "busy after reset");
        check_equal(result.found, 0, "found after reset");

        for (int n = 0; n < 3; n++) begin
            run_scan(random_req({1'b1, 63'd0}, '1), "high threshold");
        end
        for (int n = 0; n < 2; n++) begin
            run_scan(random_req('0, '0), "zero threshold");
        end
        for (int n = 0; n < 2; n++) begin
            run_scan(random_req('1, '1), "all-ones threshold");
            check_equal(result.index, 0, "all-ones hit index");
        end
        back_to_back(3);
        request_while_busy();

        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
scan_pkg.sv
scan_fsm.sv
nonce_counter.sv
block_loader.sv
keccak_core.sv
scan_result.sv
sha3_scanner.sv
tb_sha3_scanner.sv
